// ==== design/core_pkg.sv ====
package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    localparam addr_t reset_pc = '0;
    // addi x0, x0, 0
    localparam inst_t inst_nop = 32'h0000_0013;

    localparam int mul_cycles = 32;

    ////////////////////
    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b,
        alu_mul
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_jal
    } br_kind_t;

endpackage

// ==== design/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic               clk,
    input  logic               reset_i,
    output logic               fetch_req_o,
    output core_pkg::addr_t    fetch_addr_o,
    input  logic               fetch_ready_i,
    input  logic               fetch_resp_valid_i,
    input  core_pkg::inst_t    fetch_resp_inst_i,
    output logic               retire_valid_o,
    output core_pkg::addr_t    retire_pc_o,
    output core_pkg::reg_idx_t retire_rd_o,
    output core_pkg::word_t    retire_data_o
);
    import core_pkg::*;

    logic     id_valid;
    addr_t    id_pc;
    inst_t    id_inst;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    reg_idx_t rf_rs1;
    reg_idx_t rf_rs2;
    word_t    rf_rs1_data;
    word_t    rf_rs2_data;

    logic     ds_valid;
    addr_t    ds_pc;
    alu_op_t  ds_alu_op;
    br_kind_t ds_br_kind;
    reg_idx_t ds_rd;
    logic     ds_rf_wen;
    word_t    ds_op_a;
    word_t    ds_op_b;
    word_t    ds_rs2_val;
    word_t    ds_imm;

    logic     exe_stall;
    logic     redirect;
    addr_t    redirect_target;
    logic     exe_fwd_valid;
    reg_idx_t exe_fwd_rd;
    word_t    exe_fwd_data;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // writeback doubles as the retire report
    assign retire_valid_o = wb_valid;
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;

    fetch_unit u_fetch (
        .clk                (clk),
        .reset_i            (reset_i),
        .fetch_req_o        (fetch_req_o),
        .fetch_addr_o       (fetch_addr_o),
        .fetch_ready_i      (fetch_ready_i),
        .fetch_resp_valid_i (fetch_resp_valid_i),
        .fetch_resp_inst_i  (fetch_resp_inst_i),
        .stall_i            (exe_stall),
        .redirect_i         (redirect),
        .redirect_target_i  (redirect_target),
        .id_valid_o         (id_valid),
        .id_pc_o            (id_pc),
        .id_inst_o          (id_inst)
    );

    inst_decoder u_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .id_valid_i   (id_valid),
        .id_pc_i      (id_pc),
        .id_inst_i    (id_inst),
        .stall_i      (exe_stall),
        .flush_i      (redirect),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rs1_val_i    (rs1_val),
        .rs2_val_i    (rs2_val),
        .ds_valid_o   (ds_valid),
        .ds_pc_o      (ds_pc),
        .ds_alu_op_o  (ds_alu_op),
        .ds_br_kind_o (ds_br_kind),
        .ds_rd_o      (ds_rd),
        .ds_rf_wen_o  (ds_rf_wen),
        .ds_op_a_o    (ds_op_a),
        .ds_op_b_o    (ds_op_b),
        .ds_rs2_val_o (ds_rs2_val),
        .ds_imm_o     (ds_imm)
    );

    operand_select u_opsel (
        .rs1_i           (rs1),
        .rs2_i           (rs2),
        .exe_fwd_valid_i (exe_fwd_valid),
        .exe_fwd_rd_i    (exe_fwd_rd),
        .exe_fwd_data_i  (exe_fwd_data),
        .wb_valid_i      (wb_valid),
        .wb_rd_i         (wb_rd),
        .wb_data_i       (wb_data),
        .rf_rs1_o        (rf_rs1),
        .rf_rs2_o        (rf_rs2),
        .rf_rs1_data_i   (rf_rs1_data),
        .rf_rs2_data_i   (rf_rs2_data),
        .rs1_val_o       (rs1_val),
        .rs2_val_o       (rs2_val)
    );

    exec_unit u_exec (
        .clk               (clk),
        .reset_i           (reset_i),
        .ds_valid_i        (ds_valid),
        .ds_pc_i           (ds_pc),
        .ds_alu_op_i       (ds_alu_op),
        .ds_br_kind_i      (ds_br_kind),
        .ds_rd_i           (ds_rd),
        .ds_rf_wen_i       (ds_rf_wen),
        .ds_op_a_i         (ds_op_a),
        .ds_op_b_i         (ds_op_b),
        .ds_rs2_val_i      (ds_rs2_val),
        .ds_imm_i          (ds_imm),
        .exe_stall_o       (exe_stall),
        .redirect_o        (redirect),
        .redirect_target_o (redirect_target),
        .exe_fwd_valid_o   (exe_fwd_valid),
        .exe_fwd_rd_o      (exe_fwd_rd),
        .exe_fwd_data_o    (exe_fwd_data),
        .wb_valid_o        (wb_valid),
        .wb_rd_o           (wb_rd),
        .wb_data_o         (wb_data),
        .retire_pc_o       (retire_pc_o)
    );

    reg_file u_rf (
        .clk       (clk),
        .reset_i   (reset_i),
        .wen_i     (wb_valid),
        .wr_rd_i   (wb_rd),
        .wr_data_i (wb_data),
        .rd_a_i    (rf_rs1),
        .rd_b_i    (rf_rs2),
        .data_a_o  (rf_rs1_data),
        .data_b_o  (rf_rs2_data)
    );

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ds_valid_i,
    input  core_pkg::addr_t    ds_pc_i,
    input  core_pkg::alu_op_t  ds_alu_op_i,
    input  core_pkg::br_kind_t ds_br_kind_i,
    input  core_pkg::reg_idx_t ds_rd_i,
    input  logic               ds_rf_wen_i,
    input  core_pkg::word_t    ds_op_a_i,
    input  core_pkg::word_t    ds_op_b_i,
    input  core_pkg::word_t    ds_rs2_val_i,
    input  core_pkg::word_t    ds_imm_i,
    output logic               exe_stall_o,
    output logic               redirect_o,
    output core_pkg::addr_t    redirect_target_o,
    output logic               exe_fwd_valid_o,
    output core_pkg::reg_idx_t exe_fwd_rd_o,
    output core_pkg::word_t    exe_fwd_data_o,
    output logic               wb_valid_o,
    output core_pkg::reg_idx_t wb_rd_o,
    output core_pkg::word_t    wb_data_o,
    output core_pkg::addr_t    retire_pc_o
);
    import core_pkg::*;

    logic  is_mul;
    logic  mul_busy;
    logic  mul_done;
    logic  taken;
    word_t mul_product;
    word_t alu_out;
    word_t result;

    assign is_mul      = ds_valid_i && ds_alu_op_i == alu_mul;
    // hold everything upstream until the product is out
    assign exe_stall_o = is_mul && !mul_done;

    seq_multiplier u_mul (
        .clk       (clk),
        .reset_i   (reset_i),
        .start_i   (is_mul && !mul_busy && !mul_done),
        .a_i       (ds_op_a_i),
        .b_i       (ds_op_b_i),
        .busy_o    (mul_busy),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    always_comb begin
        case (ds_alu_op_i)
            alu_sub:    alu_out = ds_op_a_i - ds_op_b_i;
            alu_and:    alu_out = ds_op_a_i & ds_op_b_i;
            alu_or:     alu_out = ds_op_a_i | ds_op_b_i;
            alu_xor:    alu_out = ds_op_a_i ^ ds_op_b_i;
            alu_pass_b: alu_out = ds_op_b_i;
            alu_mul:    alu_out = mul_product;
            default:    alu_out = ds_op_a_i + ds_op_b_i;
        endcase
    end

    ////////////////////
    // branch resolution
    always_comb begin
        case (ds_br_kind_i)
            br_eq:   taken = (ds_op_a_i == ds_rs2_val_i);
            br_ne:   taken = (ds_op_a_i != ds_rs2_val_i);
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o        = ds_valid_i && taken;
    assign redirect_target_o = ds_pc_i + ds_imm_i;
    // jal links pc + 4
    assign result = (ds_br_kind_i == br_jal) ? ds_pc_i + 32'd4 : alu_out;

    assign exe_fwd_valid_o = ds_valid_i && ds_rf_wen_i && !exe_stall_o;
    assign exe_fwd_rd_o    = ds_rd_i;
    assign exe_fwd_data_o  = result;

    ////////////////////
    // writeback register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ds_valid_i && !exe_stall_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o     <= ds_rd_i;
        wb_data_o   <= (ds_rd_i == 5'd0) ? '0 : result;
        retire_pc_o <= ds_pc_i;
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clk,
    input  logic            reset_i,
    output logic            fetch_req_o,
    output core_pkg::addr_t fetch_addr_o,
    input  logic            fetch_ready_i,
    input  logic            fetch_resp_valid_i,
    input  core_pkg::inst_t fetch_resp_inst_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  core_pkg::addr_t redirect_target_i,
    output logic            id_valid_o,
    output core_pkg::addr_t id_pc_o,
    output core_pkg::inst_t id_inst_o
);
    import core_pkg::*;

    logic  req_q;
    logic  outstanding;
    logic  discard;
    logic  can_issue;
    addr_t fetch_pc;
    addr_t issue_pc;
    addr_t req_addr;

    // only one in flight, and id must be free or draining
    assign can_issue = !req_q && !outstanding && (!id_valid_o || !stall_i);
    assign issue_pc  = redirect_i ? redirect_target_i : fetch_pc;

    assign fetch_req_o  = req_q;
    assign fetch_addr_o = req_addr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_q       <= 1'b0;
            outstanding <= 1'b0;
            discard     <= 1'b0;
            fetch_pc    <= reset_pc;
        end else begin
            if (can_issue) begin
                req_q    <= 1'b1;
                fetch_pc <= issue_pc + 32'd4;
            end else if (redirect_i) begin
                fetch_pc <= redirect_target_i;
            end
            if (req_q && fetch_ready_i) begin
                req_q       <= 1'b0;
                outstanding <= 1'b1;
            end
            if (fetch_resp_valid_i) begin
                outstanding <= 1'b0;
            end
            // wrong-path request still to come back
            if (redirect_i && (req_q || (outstanding && !fetch_resp_valid_i))) begin
                discard <= 1'b1;
            end else if (fetch_resp_valid_i) begin
                discard <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_issue) begin
            req_addr <= issue_pc;
        end
    end

    ////////////////////
    // decode input register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_valid_o <= 1'b0;
        end else if (redirect_i) begin
            id_valid_o <= 1'b0;
        end else if (fetch_resp_valid_i && !discard) begin
            id_valid_o <= 1'b1;
        end else if (!stall_i) begin
            id_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_resp_valid_i && !discard) begin
            id_pc_o   <= req_addr;
            id_inst_o <= fetch_resp_inst_i;
        end
    end

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               id_valid_i,
    input  core_pkg::addr_t    id_pc_i,
    input  core_pkg::inst_t    id_inst_i,
    input  logic               stall_i,
    input  logic               flush_i,
    output core_pkg::reg_idx_t rs1_o,
    output core_pkg::reg_idx_t rs2_o,
    input  core_pkg::word_t    rs1_val_i,
    input  core_pkg::word_t    rs2_val_i,
    output logic               ds_valid_o,
    output core_pkg::addr_t    ds_pc_o,
    output core_pkg::alu_op_t  ds_alu_op_o,
    output core_pkg::br_kind_t ds_br_kind_o,
    output core_pkg::reg_idx_t ds_rd_o,
    output logic               ds_rf_wen_o,
    output core_pkg::word_t    ds_op_a_o,
    output core_pkg::word_t    ds_op_b_o,
    output core_pkg::word_t    ds_rs2_val_o,
    output core_pkg::word_t    ds_imm_o
);
    import core_pkg::*;

    inst_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t    alu_op;
    br_kind_t   br_kind;
    logic       rf_wen;
    logic       use_imm;
    word_t      imm;

    // bubbles decode as a nop
    assign inst   = id_valid_i ? id_inst_i : inst_nop;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1_o  = inst[19:15];
    assign rs2_o  = inst[24:20];

    always_comb begin
        alu_op  = alu_add;
        br_kind = br_none;
        rf_wen  = 1'b0;
        use_imm = 1'b0;
        imm     = '0;
        case (opcode)
            op_reg: begin
                rf_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = alu_add;
                    10'b0100000_000: alu_op = alu_sub;
                    10'b0000000_100: alu_op = alu_xor;
                    10'b0000000_110: alu_op = alu_or;
                    10'b0000000_111: alu_op = alu_and;
                    10'b0000001_000: alu_op = alu_mul;
                    default:         rf_wen = 1'b0;
                endcase
            end
            op_imm: begin
                // addi only
                rf_wen  = (funct3 == 3'b000);
                use_imm = 1'b1;
                imm     = {{20{inst[31]}}, inst[31:20]};
            end
            op_lui: begin
                alu_op  = alu_pass_b;
                rf_wen  = 1'b1;
                use_imm = 1'b1;
                imm     = {inst[31:12], 12'b0};
            end
            op_branch: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    br_kind = br_eq;
                end else if (funct3 == 3'b001) begin
                    br_kind = br_ne;
                end
            end
            op_jal: begin
                br_kind = br_jal;
                rf_wen  = 1'b1;
                imm     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                rf_wen = 1'b0;
            end
        endcase
    end

    ////////////////////
    // ds stage register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ds_valid_o <= 1'b0;
        end else if (flush_i) begin
            ds_valid_o <= 1'b0;
        end else if (!stall_i) begin
            ds_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ds_pc_o      <= id_pc_i;
            ds_alu_op_o  <= alu_op;
            ds_br_kind_o <= br_kind;
            ds_rd_o      <= rf_wen ? inst[11:7] : 5'd0;
            ds_rf_wen_o  <= rf_wen;
            ds_op_a_o    <= rs1_val_i;
            ds_op_b_o    <= use_imm ? imm : rs2_val_i;
            ds_rs2_val_o <= rs2_val_i;
            ds_imm_o     <= imm;
        end
    end

endmodule

// ==== design/operand_select.sv ====
`timescale 1ns/1ps

module operand_select (
    input  core_pkg::reg_idx_t rs1_i,
    input  core_pkg::reg_idx_t rs2_i,
    input  logic               exe_fwd_valid_i,
    input  core_pkg::reg_idx_t exe_fwd_rd_i,
    input  core_pkg::word_t    exe_fwd_data_i,
    input  logic               wb_valid_i,
    input  core_pkg::reg_idx_t wb_rd_i,
    input  core_pkg::word_t    wb_data_i,
    output core_pkg::reg_idx_t rf_rs1_o,
    output core_pkg::reg_idx_t rf_rs2_o,
    input  core_pkg::word_t    rf_rs1_data_i,
    input  core_pkg::word_t    rf_rs2_data_i,
    output core_pkg::word_t    rs1_val_o,
    output core_pkg::word_t    rs2_val_o
);

    logic a_from_exe;
    logic a_from_wb;
    logic b_from_exe;
    logic b_from_wb;

    assign rf_rs1_o = rs1_i;
    assign rf_rs2_o = rs2_i;

    // x0 never matches a producer
    assign a_from_exe = exe_fwd_valid_i && rs1_i != 5'd0 && exe_fwd_rd_i == rs1_i;
    assign a_from_wb  = wb_valid_i && rs1_i != 5'd0 && wb_rd_i == rs1_i;
    assign b_from_exe = exe_fwd_valid_i && rs2_i != 5'd0 && exe_fwd_rd_i == rs2_i;
    assign b_from_wb  = wb_valid_i && rs2_i != 5'd0 && wb_rd_i == rs2_i;

    // youngest producer first
    assign rs1_val_o = a_from_exe ? exe_fwd_data_i : a_from_wb ? wb_data_i : rf_rs1_data_i;
    assign rs2_val_o = b_from_exe ? exe_fwd_data_i : b_from_wb ? wb_data_i : rf_rs2_data_i;

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               wen_i,
    input  core_pkg::reg_idx_t wr_rd_i,
    input  core_pkg::word_t    wr_data_i,
    input  core_pkg::reg_idx_t rd_a_i,
    input  core_pkg::reg_idx_t rd_b_i,
    output core_pkg::word_t    data_a_o,
    output core_pkg::word_t    data_b_o
);
    import core_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && wr_rd_i != 5'd0) begin
            regs[wr_rd_i] <= wr_data_i;
        end
    end

    assign data_a_o = (rd_a_i == 5'd0) ? '0 : regs[rd_a_i];
    assign data_b_o = (rd_b_i == 5'd0) ? '0 : regs[rd_b_i];

endmodule

// ==== design/seq_multiplier.sv ====
`timescale 1ns/1ps

module seq_multiplier (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            start_i,
    input  core_pkg::word_t a_i,
    input  core_pkg::word_t b_i,
    output logic            busy_o,
    output logic            done_o,
    output core_pkg::word_t product_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {idle, busy, done} state_t;
    typedef logic [$clog2(mul_cycles)-1:0] count_t;

    state_t state;
    count_t count;
    word_t  mcand;
    word_t  mplier;
    word_t  acc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start_i) begin
                        state <= busy;
                        count <= '0;
                    end
                end
                busy: begin
                    if (count == count_t'(mul_cycles - 1)) begin
                        state <= done;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (state == idle && start_i) begin
            mcand  <= a_i;
            mplier <= b_i;
            acc    <= '0;
        end else if (state == busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign busy_o    = (state == busy);
    assign done_o    = (state == done);
    assign product_o = acc;

endmodule

// ==== filelist.f ====
design/core_pkg.sv
design/reg_file.sv
design/seq_multiplier.sv
design/operand_select.sv
design/inst_decoder.sv
design/exec_unit.sv
design/fetch_unit.sv
design/core_top.sv
test/tb_clock.sv
test/imem_model.sv
test/tb_core.sv

// ==== test/imem_model.sv ====
`timescale 1ns/1ps

module imem_model (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            req_i,
    input  core_pkg::addr_t addr_i,
    output logic            ready_o,
    output logic            resp_valid_o,
    output core_pkg::inst_t resp_inst_o,
    input  logic [1:0]      mode_i
);
    import core_pkg::*;

    inst_t      mem [0:63];
    logic       rst_q;
    logic [1:0] mode_q;
    logic       acc_q;
    addr_t      acc_addr;
    logic       pending;
    addr_t      pend_addr;
    int         wait_n;
    int         low_run;

    initial begin
        ready_o      = 1'b0;
        resp_valid_o = 1'b0;
        resp_inst_o  = '0;
        pending      = 1'b0;
        wait_n       = 0;
        low_run      = 0;
    end

    // acceptance, reset and mode are seen at the rising edge
    always @(posedge clk) begin
        acc_q    <= req_i && ready_o && !reset_i;
        acc_addr <= addr_i;
        rst_q    <= reset_i;
        mode_q   <= mode_i;
    end

    ////////////////////
    // outputs move on the falling edge
    always @(negedge clk) begin
        resp_valid_o = 1'b0;
        if (rst_q) begin
            pending = 1'b0;
            ready_o = 1'b0;
        end else begin
            if (acc_q) begin
                pending   = 1'b1;
                pend_addr = acc_addr;
                case (mode_q)
                    2'd1:    wait_n = 1;
                    2'd2:    wait_n = 4;
                    default: wait_n = 1 + $urandom % 4;
                endcase
            end
            if (pending) begin
                if (wait_n <= 1) begin
                    resp_valid_o = 1'b1;
                    resp_inst_o  = mem[pend_addr[7:2]];
                    pending      = 1'b0;
                end else begin
                    wait_n = wait_n - 1;
                end
            end
            case (mode_q)
                2'd1: ready_o = 1'b1;
                2'd2: begin
                    // long low runs with single ready cycles between
                    if (low_run > 0) begin
                        low_run = low_run - 1;
                        ready_o = 1'b0;
                    end else begin
                        low_run = 6 + $urandom % 10;
                        ready_o = 1'b1;
                    end
                end
                default: ready_o = ($urandom % 4) != 0;
            endcase
        end
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #10 clk_o = ~clk_o;
    end

endmodule

// ==== test/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    logic     clk;
    logic     reset_i;
    logic     fetch_req_o;
    addr_t    fetch_addr_o;
    logic     fetch_ready_i;
    logic     fetch_resp_valid_i;
    inst_t    fetch_resp_inst_i;
    logic     retire_valid_o;
    addr_t    retire_pc_o;
    reg_idx_t retire_rd_o;
    word_t    retire_data_o;
    logic [1:0] mem_mode;

    int value_errors;
    int other_errors;
    int cycles;
    int cycle_limit;

    inst_t       prog [$];
    word_t       m_regs [0:31];
    addr_t       m_pc;
    word_t       mul_a;
    word_t       mul_b;
    // retire entries packed as {pc, rd, data}
    logic [68:0] last_trace [$];
    logic [68:0] ref_trace [$];

    tb_clock u_clk (.clk_o(clk));

    imem_model u_imem (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (fetch_req_o),
        .addr_i       (fetch_addr_o),
        .ready_o      (fetch_ready_i),
        .resp_valid_o (fetch_resp_valid_i),
        .resp_inst_o  (fetch_resp_inst_i),
        .mode_i       (mem_mode)
    );

    core_top dut (
        .clk                (clk),
        .reset_i            (reset_i),
        .fetch_req_o        (fetch_req_o),
        .fetch_addr_o       (fetch_addr_o),
        .fetch_ready_i      (fetch_ready_i),
        .fetch_resp_valid_i (fetch_resp_valid_i),
        .fetch_resp_inst_i  (fetch_resp_inst_i),
        .retire_valid_o     (retire_valid_o),
        .retire_pc_o        (retire_pc_o),
        .retire_rd_o        (retire_rd_o),
        .retire_data_o      (retire_data_o)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////
    // instruction encoders
    function automatic inst_t rtype(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic inst_t itype(logic [11:0] imm, int rs1, int rd);
        return {imm, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic inst_t utype(logic [19:0] imm, int rd);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    function automatic inst_t btype(logic [12:0] i, int rs1, int rs2, logic [2:0] f3);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic inst_t jtype(logic [20:0] i, int rd);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic load_const(int rd, word_t v);
        word_t adj;
        adj = v + 32'h800;
        prog.push_back(utype(adj[31:12], rd));
        prog.push_back(itype(v[11:0], rd, rd));
    endtask

    task automatic build_prog(int id);
        prog.delete();
        case (id)
            0: begin
                prog.push_back(itype(-12'sd5, 0, 1));
                prog.push_back(itype(12'd100, 0, 2));
                prog.push_back(rtype(7'h00, 2, 1, 3'b000, 3));
                prog.push_back(rtype(7'h20, 1, 3, 3'b000, 4));
                prog.push_back(rtype(7'h00, 2, 4, 3'b111, 5));
                prog.push_back(rtype(7'h00, 1, 5, 3'b110, 6));
                prog.push_back(rtype(7'h00, 3, 6, 3'b100, 7));
                prog.push_back(utype(20'habcde, 8));
                prog.push_back(itype(-12'sd1, 8, 8));
                prog.push_back(rtype(7'h00, 8, 8, 3'b000, 0));
                prog.push_back(rtype(7'h00, 8, 0, 3'b000, 9));
                prog.push_back(rtype(7'h20, 9, 1, 3'b000, 10));
                // most negative immediate, -2048
                prog.push_back(itype(12'h800, 10, 11));
            end
            1: begin
                prog.push_back(itype(12'd3, 0, 1));
                prog.push_back(itype(12'd3, 0, 2));
                prog.push_back(btype(13'd8, 1, 2, 3'b000));
                prog.push_back(itype(12'd99, 0, 3));
                prog.push_back(btype(13'd8, 1, 2, 3'b001));
                prog.push_back(itype(12'd7, 0, 4));
                prog.push_back(btype(13'd12, 4, 1, 3'b001));
                prog.push_back(itype(12'd1, 0, 5));
                prog.push_back(itype(12'd2, 0, 5));
                prog.push_back(btype(13'd8, 4, 1, 3'b000));
                prog.push_back(jtype(21'd8, 6));
                prog.push_back(itype(12'd5, 0, 7));
                prog.push_back(rtype(7'h00, 4, 6, 3'b000, 8));
            end
            default: begin
                load_const(1, mul_a);
                load_const(2, mul_b);
                prog.push_back(rtype(7'h01, 2, 1, 3'b000, 3));
                prog.push_back(rtype(7'h00, 1, 3, 3'b000, 4));
                prog.push_back(rtype(7'h01, 3, 3, 3'b000, 5));
                prog.push_back(rtype(7'h00, 4, 5, 3'b000, 6));
            end
        endcase
        // self-loop ends every program
        prog.push_back(jtype(21'd0, 0));
    endtask

    function automatic int prog_cost();
        int cost;
        cost = 0;
        foreach (prog[i]) begin
            cost += 40;
            if (prog[i][6:0] == 7'b0110011 && prog[i][31:25] == 7'h01) begin
                cost += mul_cycles;
            end
        end
        return cost;
    endfunction

    ////////////////////
    // reference ISA model
    task automatic model_step(output addr_t pc, output reg_idx_t rd, output word_t data);
        inst_t inst;
        word_t a;
        word_t b;
        word_t val;
        logic  wr;
        addr_t next;
        inst = prog[m_pc >> 2];
        a    = m_regs[inst[19:15]];
        b    = m_regs[inst[24:20]];
        wr   = 1'b0;
        val  = '0;
        next = m_pc + 4;
        case (inst[6:0])
            7'b0110011: begin
                wr = 1'b1;
                case ({inst[31:25], inst[14:12]})
                    10'b0000000_000: val = a + b;
                    10'b0100000_000: val = a - b;
                    10'b0000000_100: val = a ^ b;
                    10'b0000000_110: val = a | b;
                    10'b0000000_111: val = a & b;
                    10'b0000001_000: val = a * b;
                    default:         wr = 1'b0;
                endcase
            end
            7'b0010011: begin
                wr  = (inst[14:12] == 3'b000);
                val = a + {{20{inst[31]}}, inst[31:20]};
            end
            7'b0110111: begin
                wr  = 1'b1;
                val = {inst[31:12], 12'b0};
            end
            7'b1100011: begin
                if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b)) begin
                    next = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                wr   = 1'b1;
                val  = m_pc + 4;
                next = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        pc   = m_pc;
        rd   = wr ? inst[11:7] : 5'd0;
        data = (rd == 5'd0) ? '0 : val;
        if (rd != 5'd0) begin
            m_regs[rd] = val;
        end
        m_pc = next;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_i = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!fetch_req_o && !retire_valid_o) else begin
                other_errors++;
                $display("request or retire seen while reset is held");
            end
        end
        reset_i = 1'b0;
    endtask

    task automatic run_program(int id, logic [1:0] mode);
        addr_t    exp_pc;
        reg_idx_t exp_rd;
        word_t    exp_data;
        addr_t    loop_pc;
        logic     done;
        build_prog(id);
        // address-tagged nops past the end of the program
        for (int i = 0; i < 64; i++) begin
            u_imem.mem[i] = (i < prog.size()) ? prog[i] : itype(12'(i), 0, 0);
        end
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        m_pc     = reset_pc;
        loop_pc  = (prog.size() - 1) * 4;
        mem_mode = mode;
        last_trace.delete();
        apply_reset();
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (retire_valid_o) begin
                model_step(exp_pc, exp_rd, exp_data);
                assert (retire_pc_o == exp_pc) else begin
                    value_errors++;
                    $display("FAILED retire_pc_o got %h expected %h", retire_pc_o, exp_pc);
                end
                assert (retire_rd_o == exp_rd) else begin
                    value_errors++;
                    $display("FAILED retire_rd_o got %h expected %h", retire_rd_o, exp_rd);
                end
                assert (retire_data_o == exp_data) else begin
                    value_errors++;
                    $display("FAILED retire_data_o got %h expected %h",
                             retire_data_o, exp_data);
                end
                last_trace.push_back({retire_pc_o, retire_rd_o, retire_data_o});
                done = (retire_pc_o == loop_pc);
            end
        end
    endtask

    task automatic check_reset();
        mem_mode = 2'd0;
        apply_reset();
        @(negedge clk);
        assert (fetch_req_o) else begin
            other_errors++;
            $display("no fetch request in the first cycle after reset");
        end
        assert (fetch_addr_o == reset_pc) else begin
            value_errors++;
            $display("FAILED fetch_addr_o got %h expected %h", fetch_addr_o, reset_pc);
        end
    endtask

    task automatic check_backpressure(int id);
        run_program(id, 2'd1);
        ref_trace = last_trace;
        run_program(id, 2'd2);
        assert (last_trace.size() == ref_trace.size()) else begin
            other_errors++;
            $display("retire count differs under back-pressure for program %0d", id);
        end
        foreach (ref_trace[i]) begin
            if (i < last_trace.size()) begin
                assert (last_trace[i] == ref_trace[i]) else begin
                    value_errors++;
                    $display("FAILED retire entry %0d got %h expected %h",
                             i, last_trace[i], ref_trace[i]);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(97));
        reset_i      = 1'b1;
        mem_mode     = 2'd0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        mul_a        = $urandom;
        mul_b        = $urandom;
        cycle_limit  = 0;
        // programs 1 and 2 run twice more in the back-pressure test
        for (int id = 0; id < 3; id++) begin
            build_prog(id);
            cycle_limit += (id == 0) ? prog_cost() : 3 * prog_cost();
        end
        check_reset();
        run_program(0, 2'd0);
        run_program(1, 2'd0);
        run_program(2, 2'd0);
        check_backpressure(1);
        check_backpressure(2);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
